// ==== rtl/rv32_isa_pkg.sv ====
// ##################################################
// RV32IM encoding definitions: word and register
// index types, major opcodes, load/store widths and
// instruction field positions
// ##################################################
`default_nettype none

package rv32_isa_pkg;

  // Basic data types
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes kept by the decode stage
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_t;

  // funct3 for loads and stores
  typedef enum logic [2:0] {
    LW_B  = 3'b000,
    LW_H  = 3'b001,
    LW_W  = 3'b010,
    LW_BU = 3'b100,
    LW_HU = 3'b101
  } load_width_t;

  // funct7 of MUL/DIV/REM group
  localparam logic [6:0] M_FUNCT7 = 7'b0000001;

  // Low bit of each field in the 32-bit word
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

// ==== rtl/decode_types_pkg.sv ====
// ##################################################
// Decode stage micro-architecture types: functional
// units, operations, operand selects, control and
// per-unit issue payloads
// ##################################################
`default_nettype none

package decode_types_pkg;

  // Functional units, also the credit vector index
  typedef enum logic [1:0] {
    FU_ARITH = 2'd0,
    FU_MUL   = 2'd1,
    FU_DIV   = 2'd2,
    FU_LS    = 2'd3
  } fu_t;

  localparam int NUM_FU = 4;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // Same order as funct3 of the M extension
  typedef enum logic [2:0] {
    M_MUL,
    M_MULH,
    M_MULHSU,
    M_MULHU,
    M_DIV,
    M_DIVU,
    M_REM,
    M_REMU
  } m_op_t;

  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;

  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_SHAMT, B_IMM_U} b_sel_t;

  typedef struct packed {
    rv32_isa_pkg::word_t instr;
    rv32_isa_pkg::word_t pc;
  } fetch_pkt_t;

  typedef struct packed {
    fu_t                       fu;
    alu_op_t                   alu_op;
    m_op_t                     m_op;
    a_sel_t                    a_sel;
    b_sel_t                    b_sel;
    logic                      is_store;
    rv32_isa_pkg::load_width_t width;
    rv32_isa_pkg::reg_idx_t    rd;
    logic                      wen;
  } ctrl_t;

  typedef struct packed {
    alu_op_t                alu_op;
    rv32_isa_pkg::word_t    port_a;
    rv32_isa_pkg::word_t    port_b;
    rv32_isa_pkg::reg_idx_t rd;
  } arith_issue_t;

  // Shared by the multiply and divide units
  typedef struct packed {
    m_op_t                  m_op;
    rv32_isa_pkg::word_t    rs1_data;
    rv32_isa_pkg::word_t    rs2_data;
    rv32_isa_pkg::reg_idx_t rd;
  } muldiv_issue_t;

  typedef struct packed {
    logic                      is_store;
    rv32_isa_pkg::load_width_t width;
    rv32_isa_pkg::word_t       base;
    rv32_isa_pkg::word_t       offset;
    rv32_isa_pkg::word_t       store_data;
    rv32_isa_pkg::reg_idx_t    rd;
  } ls_issue_t;

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
// ##################################################
// Combinational instruction decoder: opcode, funct3
// and funct7 to target unit, operation, operand
// selects, access width and destination register
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module instr_decoder (
  input  rv32_isa_pkg::word_t     instr,
  output decode_types_pkg::ctrl_t ctrl,
  output rv32_isa_pkg::reg_idx_t  rs1_addr,
  output rv32_isa_pkg::reg_idx_t  rs2_addr
);

  import rv32_isa_pkg::*;
  import decode_types_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_shift_imm;

  // ALU operation from funct3; alt is instr bit 30
  function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic alt,
                                         input logic allow_sub);
    alu_op_t op;
    case (f3)
      3'b000:  op = (allow_sub && alt) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[FUNCT3_LSB +: 3];
  assign funct7   = instr[FUNCT7_LSB +: 7];
  assign rs1_addr = instr[RS1_LSB +: 5];
  assign rs2_addr = instr[RS2_LSB +: 5];

  // SLLI, SRLI and SRAI take the shift amount from the rs2 field
  assign is_shift_imm = (funct3 == 3'b001) || (funct3 == 3'b101);

  always_comb begin
    // Defaults describe a register-register ALU op
    ctrl.fu       = FU_ARITH;
    ctrl.alu_op   = ALU_ADD;
    ctrl.m_op     = m_op_t'(funct3);
    ctrl.a_sel    = A_RS1;
    ctrl.b_sel    = B_RS2;
    ctrl.is_store = 1'b0;
    ctrl.width    = load_width_t'(funct3);
    ctrl.rd       = instr[RD_LSB +: 5];
    ctrl.wen      = 1'b1;

    case (opcode)
      OP: begin
        if (funct7 == M_FUNCT7) begin
          // funct3[2] splits MUL* from DIV/REM
          ctrl.fu = funct3[2] ? FU_DIV : FU_MUL;
        end else begin
          ctrl.alu_op = alu_decode(funct3, funct7[5], 1'b1);
        end
      end
      OP_IMM: begin
        ctrl.alu_op = alu_decode(funct3, funct7[5], 1'b0);
        ctrl.b_sel  = is_shift_imm ? B_SHAMT : B_IMM_I;
      end
      LUI: begin
        ctrl.a_sel = A_ZERO;
        ctrl.b_sel = B_IMM_U;
      end
      AUIPC: begin
        ctrl.a_sel = A_PC;
        ctrl.b_sel = B_IMM_U;
      end
      LOAD: begin
        ctrl.fu = FU_LS;
      end
      STORE: begin
        ctrl.fu       = FU_LS;
        ctrl.is_store = 1'b1;
        ctrl.wen      = 1'b0;
      end
      default: begin
        // Other opcodes are not sent by fetch
        ctrl.fu = FU_ARITH;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/operand_builder.sv ====
// ##################################################
// Immediate sign extension and operand muxes that
// build the arith, mul/div and load/store payloads
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module operand_builder (
  input  decode_types_pkg::ctrl_t         ctrl,
  input  rv32_isa_pkg::word_t             pc,
  input  rv32_isa_pkg::word_t             instr,
  input  rv32_isa_pkg::word_t             rs1_data,
  input  rv32_isa_pkg::word_t             rs2_data,
  output decode_types_pkg::arith_issue_t  arith_operands,
  output decode_types_pkg::muldiv_issue_t muldiv_operands,
  output decode_types_pkg::ls_issue_t     ls_operands
);

  import rv32_isa_pkg::*;
  import decode_types_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t shamt;
  word_t port_a;
  word_t port_b;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};
  assign shamt = {27'b0, instr[RS2_LSB +: 5]};

  always_comb begin
    case (ctrl.a_sel)
      A_RS1:   port_a = rs1_data;
      A_PC:    port_a = pc;
      default: port_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.b_sel)
      B_RS2:   port_b = rs2_data;
      B_IMM_I: port_b = imm_i;
      B_SHAMT: port_b = shamt;
      default: port_b = imm_u;
    endcase
  end

  assign arith_operands  = '{alu_op: ctrl.alu_op, port_a: port_a, port_b: port_b, rd: ctrl.rd};
  assign muldiv_operands = '{m_op: ctrl.m_op, rs1_data: rs1_data, rs2_data: rs2_data,
                             rd: ctrl.rd};

  // Stores write no register, so rd goes to x0
  assign ls_operands.is_store   = ctrl.is_store;
  assign ls_operands.width      = ctrl.width;
  assign ls_operands.base       = rs1_data;
  assign ls_operands.offset     = ctrl.is_store ? imm_s : imm_i;
  assign ls_operands.store_data = rs2_data;
  assign ls_operands.rd         = ctrl.wen ? ctrl.rd : '0;

endmodule

`default_nettype wire

// ==== rtl/credit_counter.sv ====
// ##################################################
// Free-slot counter for one functional unit
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module credit_counter #(
  parameter int CREDITS = 4
) (
  input  logic CLK,
  input  logic nRST,
  input  logic take,
  input  logic give,
  output logic has_credit
);

  localparam int CW = $clog2(CREDITS + 1);

  logic [CW-1:0] count;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= CW'(CREDITS);
    end else if (take && !give) begin
      count <= count - 1'b1;
    end else if (give && !take) begin
      count <= count + 1'b1;
    end
  end

  // A returned credit is usable from the next edge on
  assign has_credit = (count != '0);

  a_no_take_empty: assert property (@(posedge CLK) disable iff (!nRST)
    take |-> (count != '0));

  // Unit must not hand back more than it was given
  a_no_give_full: assert property (@(posedge CLK) disable iff (!nRST)
    give |-> (count != CW'(CREDITS)));

endmodule

`default_nettype wire

// ==== rtl/dispatch_regs.sv ====
// ##################################################
// Accept decision, flush drop and the registered
// issue outputs of the four functional units
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module dispatch_regs (
  input  logic                                  CLK,
  input  logic                                  nRST,
  input  logic                                  in_valid,
  input  logic                                  flush,
  input  decode_types_pkg::fu_t                 fu,
  input  logic [decode_types_pkg::NUM_FU-1:0]   has_credit,
  input  decode_types_pkg::arith_issue_t        arith_operands,
  input  decode_types_pkg::muldiv_issue_t       muldiv_operands,
  input  decode_types_pkg::ls_issue_t           ls_operands,
  output logic                                  in_ready,
  output logic [decode_types_pkg::NUM_FU-1:0]   take,
  output logic                                  arith_valid,
  output logic                                  mul_valid,
  output logic                                  div_valid,
  output logic                                  ls_valid,
  output decode_types_pkg::arith_issue_t        arith_issue,
  output decode_types_pkg::muldiv_issue_t       muldiv_issue,
  output decode_types_pkg::ls_issue_t           ls_issue
);

  import decode_types_pkg::*;

  logic issue;

  // Flush lets fetch drop the packet without waiting on credits
  assign in_ready = flush || has_credit[fu];
  assign issue    = in_valid && in_ready && !flush;

  always_comb begin
    take     = '0;
    take[fu] = issue;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      arith_valid <= 1'b0;
      mul_valid   <= 1'b0;
      div_valid   <= 1'b0;
      ls_valid    <= 1'b0;
    end else begin
      arith_valid <= take[FU_ARITH];
      mul_valid   <= take[FU_MUL];
      div_valid   <= take[FU_DIV];
      ls_valid    <= take[FU_LS];
    end
  end

  // Payloads only change when their unit is issued to
  always_ff @(posedge CLK) begin
    if (take[FU_ARITH]) begin
      arith_issue <= arith_operands;
    end
    if (take[FU_MUL] || take[FU_DIV]) begin
      muldiv_issue <= muldiv_operands;
    end
    if (take[FU_LS]) begin
      ls_issue <= ls_operands;
    end
  end

  a_one_valid: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({arith_valid, mul_valid, div_valid, ls_valid}));

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// ##################################################
// Decode stage top: decoder, operand builder,
// per-unit credit counters and issue registers
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module decode_stage #(
  parameter int CREDITS = 4
) (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                in_valid,
  input  decode_types_pkg::fetch_pkt_t        in_pkt,
  input  rv32_isa_pkg::word_t                 rs1_data,
  input  rv32_isa_pkg::word_t                 rs2_data,
  input  logic                                flush,
  input  logic [decode_types_pkg::NUM_FU-1:0] credit_return,
  output logic                                in_ready,
  output rv32_isa_pkg::reg_idx_t              rs1_addr,
  output rv32_isa_pkg::reg_idx_t              rs2_addr,
  output logic                                arith_valid,
  output decode_types_pkg::arith_issue_t      arith_issue,
  output logic                                mul_valid,
  output logic                                div_valid,
  output decode_types_pkg::muldiv_issue_t     muldiv_issue,
  output logic                                ls_valid,
  output decode_types_pkg::ls_issue_t         ls_issue
);

  import rv32_isa_pkg::*;
  import decode_types_pkg::*;

  ctrl_t         ctrl;
  arith_issue_t  arith_operands;
  muldiv_issue_t muldiv_operands;
  ls_issue_t     ls_operands;
  logic [NUM_FU-1:0] take;
  logic [NUM_FU-1:0] has_credit;

  instr_decoder u_decoder (
    .instr    (in_pkt.instr),
    .ctrl     (ctrl),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr)
  );

  operand_builder u_operands (
    .ctrl            (ctrl),
    .pc              (in_pkt.pc),
    .instr           (in_pkt.instr),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .arith_operands  (arith_operands),
    .muldiv_operands (muldiv_operands),
    .ls_operands     (ls_operands)
  );

  // One counter per unit, indexed by fu_t
  for (genvar i = 0; i < NUM_FU; i++) begin : g_credit
    credit_counter #(
      .CREDITS (CREDITS)
    ) u_credit (
      .CLK        (CLK),
      .nRST       (nRST),
      .take       (take[i]),
      .give       (credit_return[i]),
      .has_credit (has_credit[i])
    );
  end

  dispatch_regs u_dispatch (
    .CLK             (CLK),
    .nRST            (nRST),
    .in_valid        (in_valid),
    .flush           (flush),
    .fu              (ctrl.fu),
    .has_credit      (has_credit),
    .arith_operands  (arith_operands),
    .muldiv_operands (muldiv_operands),
    .ls_operands     (ls_operands),
    .in_ready        (in_ready),
    .take            (take),
    .arith_valid     (arith_valid),
    .mul_valid       (mul_valid),
    .div_valid       (div_valid),
    .ls_valid        (ls_valid),
    .arith_issue     (arith_issue),
    .muldiv_issue    (muldiv_issue),
    .ls_issue        (ls_issue)
  );

  // Fetch only offers opcodes the decoder knows
  a_legal_opcode: assert property (@(posedge CLK) disable iff (!nRST)
    in_valid |-> (in_pkt.instr[6:0] inside {OP, OP_IMM, LUI, AUIPC, LOAD, STORE}));

endmodule

`default_nettype wire

// ==== sim/decode_checks.svh ====
// ##################################################
// Reference model of the decode rules, expected
// issue queues per unit and typed compare tasks
// ##################################################
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

// Expected payloads, pushed at the accepting edge
arith_issue_t  arith_q[$];
muldiv_issue_t mul_q[$];
muldiv_issue_t div_q[$];
ls_issue_t     ls_q[$];

int arith_errs;
int muldiv_errs;
int ls_errs;
int ctrl_errs;

// Target unit from the major opcode, funct7 and funct3[2]
function automatic fu_t expected_unit(input word_t ins);
  fu_t u;
  u = FU_ARITH;
  if (ins[6:0] == LOAD || ins[6:0] == STORE) begin
    u = FU_LS;
  end else if (ins[6:0] == OP && ins[31:25] == M_FUNCT7) begin
    u = ins[14] ? FU_DIV : FU_MUL;
  end
  return u;
endfunction

function automatic alu_op_t expected_alu(input word_t ins);
  alu_op_t by_f3 [8];
  alu_op_t op;
  by_f3 = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  op = by_f3[ins[14:12]];
  // Bit 30 picks SRA for both forms, SUB only for register-register
  if (ins[30] && ins[14:12] == 3'b101) begin
    op = ALU_SRA;
  end
  if (ins[30] && ins[14:12] == 3'b000 && ins[6:0] == OP) begin
    op = ALU_SUB;
  end
  return op;
endfunction

task automatic predict(input fetch_pkt_t pkt, input word_t rs1_val, input word_t rs2_val);
  word_t         ins;
  word_t         imm_i;
  word_t         imm_s;
  arith_issue_t  a;
  muldiv_issue_t m;
  ls_issue_t     l;
  ins   = pkt.instr;
  imm_i = 32'($signed(ins[31:20]));
  imm_s = 32'($signed({ins[31:25], ins[11:7]}));
  case (expected_unit(ins))
    FU_MUL, FU_DIV: begin
      m = '{m_op: m_op_t'(ins[14:12]), rs1_data: rs1_val, rs2_data: rs2_val, rd: ins[11:7]};
      if (ins[14]) begin
        div_q.push_back(m);
      end else begin
        mul_q.push_back(m);
      end
    end
    FU_LS: begin
      l.is_store   = (ins[6:0] == STORE);
      l.width      = load_width_t'(ins[14:12]);
      l.base       = rs1_val;
      l.offset     = l.is_store ? imm_s : imm_i;
      l.store_data = rs2_val;
      l.rd         = l.is_store ? 5'd0 : ins[11:7];
      ls_q.push_back(l);
    end
    default: begin
      a = '{alu_op: expected_alu(ins), port_a: rs1_val, port_b: rs2_val, rd: ins[11:7]};
      if (ins[6:0] == OP_IMM) begin
        // Shifts carry shamt in the rs2 field
        a.port_b = (ins[13:12] == 2'b01) ? {27'd0, ins[24:20]} : imm_i;
      end
      if (ins[6:0] == LUI || ins[6:0] == AUIPC) begin
        a.alu_op = ALU_ADD;
        a.port_a = (ins[6:0] == LUI) ? '0 : pkt.pc;
        a.port_b = {ins[31:12], 12'd0};
      end
      arith_q.push_back(a);
    end
  endcase
endtask

task automatic compare_arith(input string name, input arith_issue_t exp,
                             input arith_issue_t act);
  if (act !== exp) begin
    arith_errs++;
    $display("mismatch %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic compare_muldiv(input string name, input muldiv_issue_t exp,
                              input muldiv_issue_t act);
  if (act !== exp) begin
    muldiv_errs++;
    $display("mismatch %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic compare_ls(input string name, input ls_issue_t exp, input ls_issue_t act);
  if (act !== exp) begin
    ls_errs++;
    $display("mismatch %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic compare_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
  if (act !== exp) begin
    ctrl_errs++;
    $display("mismatch %s expected %0d actual %0d", name, exp, act);
  end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    ctrl_errs++;
    $display("mismatch %s expected %b actual %b", name, exp, act);
  end
endtask

`endif

// ==== sim/decode_tb.sv ====
// ##################################################
// Decode stage testbench: clock and reset, register
// file model, random fetch stimulus with flush and
// delayed credit returns per functional unit
// ##################################################
`default_nettype none
`timescale 1ns/100ps

module decode_tb;

  import rv32_isa_pkg::*;
  import decode_types_pkg::*;

  localparam int CREDITS     = 3;
  localparam int NUM_CYCLES  = 4000;
  localparam int STALL_LIMIT = 200;
  localparam int DRAIN_LIMIT = 100;

  logic              CLK;
  logic              nRST;
  logic              in_valid;
  fetch_pkt_t        in_pkt;
  word_t             rs1_data;
  word_t             rs2_data;
  logic              flush;
  logic [NUM_FU-1:0] credit_return;
  logic              in_ready;
  reg_idx_t          rs1_addr;
  reg_idx_t          rs2_addr;
  logic              arith_valid;
  logic              mul_valid;
  logic              div_valid;
  logic              ls_valid;
  arith_issue_t      arith_issue;
  muldiv_issue_t     muldiv_issue;
  ls_issue_t         ls_issue;

  word_t regs [32];
  int    credits [NUM_FU];
  int    in_flight [NUM_FU];
  // Cycle at which each outstanding issue hands back its credit
  int    due [NUM_FU][$];
  int    cycle;
  int    accepted;
  int    flushed;
  bit    timed_out;

  `include "decode_checks.svh"

  decode_stage #(
    .CREDITS (CREDITS)
  ) DUT (
    .CLK           (CLK),
    .nRST          (nRST),
    .in_valid      (in_valid),
    .in_pkt        (in_pkt),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .flush         (flush),
    .credit_return (credit_return),
    .in_ready      (in_ready),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .arith_valid   (arith_valid),
    .arith_issue   (arith_issue),
    .mul_valid     (mul_valid),
    .div_valid     (div_valid),
    .muldiv_issue  (muldiv_issue),
    .ls_valid      (ls_valid),
    .ls_issue      (ls_issue)
  );

  // Register file answers in the same cycle
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Legal instruction from one of the kept classes
  function automatic word_t random_instr();
    logic [2:0] ld_f3 [5];
    logic [2:0] f3;
    word_t      ins;
    ld_f3 = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    f3    = 3'($urandom_range(0, 7));
    ins   = $urandom;
    case ($urandom_range(0, 6))
      0: begin
        ins[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) != 0) ?
                     7'h20 : 7'h00;
        ins = {ins[31:15], f3, ins[11:7], OP};
      end
      1: ins = {M_FUNCT7, ins[24:15], f3, ins[11:7], OP};
      2: begin
        if (f3 == 3'b001) begin
          ins[31:25] = 7'h00;
        end
        if (f3 == 3'b101) begin
          ins[31:25] = ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
        end
        ins = {ins[31:15], f3, ins[11:7], OP_IMM};
      end
      3: ins = {ins[31:7], LUI};
      4: ins = {ins[31:7], AUIPC};
      5: ins = {ins[31:15], ld_f3[$urandom_range(0, 4)], ins[11:7], LOAD};
      default: ins = {ins[31:15], 3'($urandom_range(0, 2)), ins[11:7], STORE};
    endcase
    return ins;
  endfunction

  // Compare what the DUT issued after the last edge
  task automatic check_issues();
    logic [NUM_FU-1:0] seen;
    logic [NUM_FU-1:0] expected;
    muldiv_issue_t     exp_m;
    seen     = {ls_valid, div_valid, mul_valid, arith_valid};
    expected = {ls_q.size() != 0, div_q.size() != 0, mul_q.size() != 0, arith_q.size() != 0};
    for (int u = 0; u < NUM_FU; u++) begin
      compare_bit($sformatf("valid of unit %0d, cycle %0d", u, cycle), expected[u], seen[u]);
      if (seen[u]) begin
        in_flight[u]++;
      end
      if (in_flight[u] > CREDITS) begin
        ctrl_errs++;
        $display("unit %0d has more than %0d issues in flight", u, CREDITS);
      end
      if (expected[u]) begin
        due[u].push_back(cycle + $urandom_range(1, 8));
      end
    end
    if (expected[FU_ARITH]) begin
      compare_arith($sformatf("arith, cycle %0d", cycle), arith_q.pop_front(), arith_issue);
    end
    if (expected[FU_MUL]) begin
      exp_m = mul_q.pop_front();
      compare_muldiv($sformatf("mul, cycle %0d", cycle), exp_m, muldiv_issue);
    end
    if (expected[FU_DIV]) begin
      exp_m = div_q.pop_front();
      compare_muldiv($sformatf("div, cycle %0d", cycle), exp_m, muldiv_issue);
    end
    if (expected[FU_LS]) begin
      compare_ls($sformatf("load/store, cycle %0d", cycle), ls_q.pop_front(), ls_issue);
    end
  endtask

  // At most one credit back per unit and cycle
  task automatic drive_returns();
    for (int u = 0; u < NUM_FU; u++) begin
      credit_return[u] = 1'b0;
      if (due[u].size() != 0 && due[u][0] <= cycle) begin
        void'(due[u].pop_front());
        credit_return[u] = 1'b1;
        in_flight[u]--;
      end
    end
  endtask

  function automatic int pending();
    int n;
    n = arith_q.size() + mul_q.size() + div_q.size() + ls_q.size();
    for (int u = 0; u < NUM_FU; u++) begin
      n += due[u].size();
    end
    return n;
  endfunction

  initial begin
    fu_t  unit;
    logic exp_ready;
    logic accept;
    int   wait_cycles;
    int   drain;
    void'($urandom(98));
    for (int i = 0; i < 32; i++) begin
      regs[i] = (i == 0) ? '0 : $urandom;
    end
    nRST          = 1'b0;
    in_valid      = 1'b0;
    in_pkt        = '0;
    flush         = 1'b0;
    credit_return = '0;
    cycle         = 0;
    accepted      = 0;
    flushed       = 0;
    timed_out     = 1'b0;
    wait_cycles   = 0;
    accept        = 1'b1;
    for (int u = 0; u < NUM_FU; u++) begin
      credits[u]   = CREDITS;
      in_flight[u] = 0;
    end
    repeat (8) @(negedge CLK);
    nRST = 1'b1;
    #10;
    compare_bit("in_ready after reset", 1'b1, in_ready);
    compare_bit("valids after reset", 1'b0, arith_valid | mul_valid | div_valid | ls_valid);

    for (int c = 0; c < NUM_CYCLES && !timed_out; c++) begin
      @(negedge CLK);
      cycle++;
      check_issues();
      drive_returns();
      // Fetch keeps an offered packet until it is taken
      if (!in_valid || accept) begin
        in_valid    = ($urandom_range(0, 3) != 0);
        in_pkt      = '{instr: random_instr(), pc: $urandom & 32'hFFFF_FFFC};
        wait_cycles = 0;
      end
      flush = ($urandom_range(0, 15) == 0);
      #10;
      unit      = expected_unit(in_pkt.instr);
      exp_ready = flush || (credits[unit] != 0);
      compare_bit($sformatf("in_ready, cycle %0d", cycle), exp_ready, in_ready);
      // Register file read ports follow the rs1 and rs2 fields
      compare_idx($sformatf("rs1_addr, cycle %0d", cycle), in_pkt.instr[19:15], rs1_addr);
      compare_idx($sformatf("rs2_addr, cycle %0d", cycle), in_pkt.instr[24:20], rs2_addr);
      accept = in_valid && exp_ready;
      if (accept && flush) begin
        flushed++;
      end else if (accept) begin
        predict(in_pkt, regs[in_pkt.instr[19:15]], regs[in_pkt.instr[24:20]]);
        credits[unit]--;
        accepted++;
      end
      for (int u = 0; u < NUM_FU; u++) begin
        credits[u] += credit_return[u];
      end
      if (in_valid && !accept) begin
        wait_cycles++;
      end
      if (wait_cycles > STALL_LIMIT) begin
        ctrl_errs++;
        timed_out = 1'b1;
        $display("timeout: fetch packet not accepted within %0d cycles", STALL_LIMIT);
      end
    end

    // Let outstanding issues and credit returns finish
    drain = 0;
    while (!timed_out && pending() != 0 && drain < DRAIN_LIMIT) begin
      @(negedge CLK);
      cycle++;
      drain++;
      in_valid = 1'b0;
      flush    = 1'b0;
      check_issues();
      drive_returns();
    end
    if (!timed_out && pending() != 0) begin
      ctrl_errs++;
      $display("timeout: issues or credit returns still pending after %0d cycles", DRAIN_LIMIT);
    end

    $display("errors arith %0d, muldiv %0d, ls %0d, control %0d (accepted %0d, flushed %0d)",
             arith_errs, muldiv_errs, ls_errs, ctrl_errs, accepted, flushed);
    if (arith_errs + muldiv_errs + ls_errs + ctrl_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
rtl/rv32_isa_pkg.sv
rtl/decode_types_pkg.sv
rtl/instr_decoder.sv
rtl/operand_builder.sv
rtl/credit_counter.sv
rtl/dispatch_regs.sv
rtl/decode_stage.sv
sim/decode_tb.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = decode_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass line in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
